// ==== src/ddr_ctrl_config.svh ====
`ifndef DDR_CTRL_CONFIG_SVH
`define DDR_CTRL_CONFIG_SVH

// data path
`define DDR_DATA_WIDTH 32
`define DDR_STRB_WIDTH 4

// AXI side works in bytes, the app port in words
`define DDR_ADDR_WIDTH 16
`define DDR_APP_ADDR_WIDTH 14

`define DDR_ID_WIDTH 4

// queue depths
`define DDR_CMD_DEPTH 4
`define DDR_RD_DEPTH 4  // read data and read tags

`endif

// ==== src/ddr_axi_pkg.sv ====
`include "ddr_ctrl_config.svh"

package ddr_axi_pkg;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // AW and AR share this layout
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;  // beats minus one
    } axi_addr_t;

    typedef struct packed {
        logic [`DDR_DATA_WIDTH-1:0] data;
        logic [`DDR_STRB_WIDTH-1:0] strb;
        logic                       last;
    } axi_w_t;

    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0] id;
        logic [1:0]               resp;
    } axi_b_t;

    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

endpackage

// ==== src/ddr_app_pkg.sv ====
`include "ddr_ctrl_config.svh"

package ddr_app_pkg;

    // command codes on app_cmd
    typedef enum logic [2:0] {
        APP_WRITE = 3'b000,
        APP_READ  = 3'b001
    } app_op_t;

    // one beat waiting for the app port
    typedef struct packed {
        app_op_t                        op;
        logic [`DDR_ID_WIDTH-1:0]       id;
        logic                           last;
        logic [`DDR_APP_ADDR_WIDTH-1:0] addr;  // word address
        logic [`DDR_DATA_WIDTH-1:0]     data;  // zero for reads
        logic [`DDR_STRB_WIDTH-1:0]     strb;
    } cmd_entry_t;

    // what a returning read word has to be labelled with
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0] id;
        logic                     last;
    } rd_tag_t;

endpackage

// ==== src/ddr_sync_fifo.sv ====
module ddr_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                         clk_if,
    input  logic                         resetn,
    input  logic                         push,
    input  logic [WIDTH-1:0]             push_data,
    input  logic                         pop,
    output logic [WIDTH-1:0]             pop_data,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign pop_data = mem[rd_ptr];  // show-ahead

    always_ff @(posedge clk_if) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

endmodule

// ==== src/axi_beat_splitter.sv ====
`include "ddr_ctrl_config.svh"

module axi_beat_splitter (
    input  logic                     clk_if,
    input  logic                     resetn,
    input  logic                     init_calib_complete,

    input  ddr_axi_pkg::axi_addr_t   s_aw,
    input  logic                     s_aw_valid,
    output logic                     s_aw_ready,
    input  ddr_axi_pkg::axi_w_t      s_w,
    input  logic                     s_w_valid,
    output logic                     s_w_ready,
    output ddr_axi_pkg::axi_b_t      s_b,
    output logic                     s_b_valid,
    input  logic                     s_b_ready,
    input  ddr_axi_pkg::axi_addr_t   s_ar,
    input  logic                     s_ar_valid,
    output logic                     s_ar_ready,

    output ddr_app_pkg::cmd_entry_t  cmd,
    output logic                     cmd_push,
    input  logic                     cmd_full
);
    localparam int BYTE_SHIFT = $clog2(`DDR_STRB_WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_READ,
        S_RESP
    } state_t;

    state_t                         state;
    logic                           last_wr;  // round-robin pointer
    logic [`DDR_ID_WIDTH-1:0]       burst_id;
    logic [`DDR_APP_ADDR_WIDTH-1:0] word_addr;
    logic [7:0]                     beats_left;
    ddr_axi_pkg::axi_addr_t         req;
    logic                           can_start;
    logic                           grant_wr;
    logic                           grant_rd;
    logic                           final_beat;

    // a write wins a tie unless the previous burst was one
    assign can_start  = init_calib_complete && (state == S_IDLE);
    assign grant_wr   = can_start && s_aw_valid && (!s_ar_valid || !last_wr);
    assign grant_rd   = can_start && s_ar_valid && !grant_wr;
    assign s_aw_ready = grant_wr;
    assign s_ar_ready = grant_rd;
    assign req        = grant_wr ? s_aw : s_ar;

    assign final_beat = (beats_left == 8'd0);
    assign s_w_ready  = (state == S_WRITE) && !cmd_full;
    assign cmd_push   = ((state == S_WRITE) && s_w_valid && !cmd_full)
                      || ((state == S_READ) && !cmd_full);

    always_comb begin
        cmd.op   = (state == S_WRITE) ? ddr_app_pkg::APP_WRITE : ddr_app_pkg::APP_READ;
        cmd.id   = burst_id;
        cmd.last = final_beat;
        cmd.addr = word_addr;
        cmd.data = (state == S_WRITE) ? s_w.data : '0;
        cmd.strb = (state == S_WRITE) ? s_w.strb : '0;
    end

    // posted write, answered once the last beat is queued
    assign s_b_valid = (state == S_RESP);
    assign s_b.id    = burst_id;
    assign s_b.resp  = ddr_axi_pkg::AXI_RESP_OKAY;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state   <= S_IDLE;
            last_wr <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (grant_wr) begin
                        state   <= S_WRITE;
                        last_wr <= 1'b1;
                    end else if (grant_rd) begin
                        state   <= S_READ;
                        last_wr <= 1'b0;
                    end
                end
                S_WRITE: if (cmd_push && final_beat) state <= S_RESP;
                S_READ:  if (cmd_push && final_beat) state <= S_IDLE;
                S_RESP:  if (s_b_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // burst bookkeeping, word address steps once per beat
    always_ff @(posedge clk_if) begin
        if (grant_wr || grant_rd) begin
            burst_id   <= req.id;
            word_addr  <= req.addr[`DDR_ADDR_WIDTH-1:BYTE_SHIFT];
            beats_left <= req.len;
        end else if (cmd_push) begin
            word_addr  <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

// ==== src/ddr_app_sequencer.sv ====
`include "ddr_ctrl_config.svh"

module ddr_app_sequencer (
    input  logic                                 clk_if,
    input  logic                                 resetn,
    input  logic                                 init_calib_complete,

    input  ddr_app_pkg::cmd_entry_t              cmd,
    input  logic                                 cmd_empty,
    output logic                                 cmd_pop,
    output ddr_app_pkg::rd_tag_t                 tag,
    output logic                                 tag_push,
    input  logic [$clog2(`DDR_RD_DEPTH+1)-1:0]   rd_count,

    output logic                                 app_cmd_en,
    output ddr_app_pkg::app_op_t                 app_cmd,
    output logic [`DDR_APP_ADDR_WIDTH-1:0]       app_addr,
    input  logic                                 app_cmd_rdy,
    output logic                                 app_wdf_wren,
    output logic [`DDR_DATA_WIDTH-1:0]           app_wdf_data,
    output logic [`DDR_STRB_WIDTH-1:0]           app_wdf_mask,
    input  logic                                 app_wdf_rdy,
    input  logic                                 app_rd_data_valid
);
    localparam int RD_DEPTH = `DDR_RD_DEPTH;
    localparam int CW       = $clog2(RD_DEPTH + 1);

    typedef enum logic {
        S_IDLE,
        S_ISSUE
    } state_t;

    state_t        state;
    logic [CW-1:0] rd_outstanding;
    logic          is_read;
    logic          rd_credit;
    logic          start;
    logic          cmd_done;
    logic          wdf_done;
    logic          rd_accept;

    // reads in flight plus words already buffered must fit the response FIFO
    assign is_read   = (cmd.op == ddr_app_pkg::APP_READ);
    assign rd_credit = (int'(rd_outstanding) + int'(rd_count)) < RD_DEPTH;
    assign start     = (state == S_IDLE) && init_calib_complete && !cmd_empty
                     && (!is_read || rd_credit);

    assign cmd_done  = !app_cmd_en || app_cmd_rdy;
    assign wdf_done  = !app_wdf_wren || app_wdf_rdy;
    assign cmd_pop   = (state == S_ISSUE) && cmd_done && wdf_done;

    // head entry is still in place when the read is accepted
    assign rd_accept = app_cmd_en && app_cmd_rdy && (app_cmd == ddr_app_pkg::APP_READ);
    assign tag_push  = rd_accept;
    assign tag.id    = cmd.id;
    assign tag.last  = cmd.last;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state          <= S_IDLE;
            app_cmd_en     <= 1'b0;
            app_wdf_wren   <= 1'b0;
            rd_outstanding <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state        <= S_ISSUE;
                        app_cmd_en   <= 1'b1;
                        app_wdf_wren <= !is_read;
                    end
                end
                S_ISSUE: begin
                    // each strobe drops on its own ready
                    if (app_cmd_rdy) app_cmd_en <= 1'b0;
                    if (app_wdf_rdy) app_wdf_wren <= 1'b0;
                    if (cmd_pop) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase

            case ({rd_accept, app_rd_data_valid})
                2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
                2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_if) begin
        if (start) begin
            app_cmd      <= cmd.op;
            app_addr     <= cmd.addr;
            app_wdf_data <= cmd.data;
            app_wdf_mask <= ~cmd.strb;  // mask bit set means keep the byte
        end
    end

endmodule

// ==== src/ddr_ctrl_top.sv ====
`include "ddr_ctrl_config.svh"

module ddr_ctrl_top (
    input  logic                            clk_if,
    input  logic                            resetn,
    input  logic                            init_calib_complete,

    input  ddr_axi_pkg::axi_addr_t          s_aw,
    input  logic                            s_aw_valid,
    output logic                            s_aw_ready,
    input  ddr_axi_pkg::axi_w_t             s_w,
    input  logic                            s_w_valid,
    output logic                            s_w_ready,
    output ddr_axi_pkg::axi_b_t             s_b,
    output logic                            s_b_valid,
    input  logic                            s_b_ready,
    input  ddr_axi_pkg::axi_addr_t          s_ar,
    input  logic                            s_ar_valid,
    output logic                            s_ar_ready,
    output ddr_axi_pkg::axi_r_t             s_r,
    output logic                            s_r_valid,
    input  logic                            s_r_ready,

    output logic                            app_cmd_en,
    output logic [2:0]                      app_cmd,
    output logic [`DDR_APP_ADDR_WIDTH-1:0]  app_addr,
    input  logic                            app_cmd_rdy,
    output logic                            app_wdf_wren,
    output logic [`DDR_DATA_WIDTH-1:0]      app_wdf_data,
    output logic [`DDR_STRB_WIDTH-1:0]      app_wdf_mask,
    input  logic                            app_wdf_rdy,
    input  logic [`DDR_DATA_WIDTH-1:0]      app_rd_data,
    input  logic                            app_rd_data_valid
);
    localparam int RD_CW = $clog2(`DDR_RD_DEPTH + 1);

    ddr_app_pkg::cmd_entry_t    cmd_in;
    ddr_app_pkg::cmd_entry_t    cmd_head;
    logic                       cmd_push;
    logic                       cmd_pop;
    logic                       cmd_full;
    logic                       cmd_empty;
    ddr_app_pkg::rd_tag_t       tag_in;
    ddr_app_pkg::rd_tag_t       tag_head;
    logic                       tag_push;
    logic                       tag_empty;
    logic [`DDR_DATA_WIDTH-1:0] rd_data_head;
    logic                       rd_data_empty;
    logic [RD_CW-1:0]           rd_count;
    logic                       r_pop;

    axi_beat_splitter u_splitter (
        .clk_if, .resetn, .init_calib_complete,
        .s_aw, .s_aw_valid, .s_aw_ready,
        .s_w, .s_w_valid, .s_w_ready,
        .s_b, .s_b_valid, .s_b_ready,
        .s_ar, .s_ar_valid, .s_ar_ready,
        .cmd(cmd_in), .cmd_push, .cmd_full
    );

    ddr_sync_fifo #(.WIDTH($bits(ddr_app_pkg::cmd_entry_t)), .DEPTH(`DDR_CMD_DEPTH)) u_cmd_fifo (
        .clk_if, .resetn,
        .push(cmd_push), .push_data(cmd_in),
        .pop(cmd_pop), .pop_data(cmd_head),
        .empty(cmd_empty), .full(cmd_full), .count()
    );

    ddr_app_sequencer u_sequencer (
        .clk_if, .resetn, .init_calib_complete,
        .cmd(cmd_head), .cmd_empty, .cmd_pop,
        .tag(tag_in), .tag_push, .rd_count,
        .app_cmd_en, .app_cmd, .app_addr, .app_cmd_rdy,
        .app_wdf_wren, .app_wdf_data, .app_wdf_mask, .app_wdf_rdy,
        .app_rd_data_valid
    );

    // tags and data fill in the same order, so the heads always pair up
    ddr_sync_fifo #(.WIDTH($bits(ddr_app_pkg::rd_tag_t)), .DEPTH(`DDR_RD_DEPTH)) u_tag_fifo (
        .clk_if, .resetn,
        .push(tag_push), .push_data(tag_in),
        .pop(r_pop), .pop_data(tag_head),
        .empty(tag_empty), .full(), .count()
    );

    ddr_sync_fifo #(.WIDTH(`DDR_DATA_WIDTH), .DEPTH(`DDR_RD_DEPTH)) u_rd_fifo (
        .clk_if, .resetn,
        .push(app_rd_data_valid), .push_data(app_rd_data),  // credit keeps this from overflowing
        .pop(r_pop), .pop_data(rd_data_head),
        .empty(rd_data_empty), .full(), .count(rd_count)
    );

    assign s_r_valid = !tag_empty && !rd_data_empty;
    assign r_pop     = s_r_valid && s_r_ready;

    always_comb begin
        s_r.id   = tag_head.id;
        s_r.data = rd_data_head;
        s_r.resp = ddr_axi_pkg::AXI_RESP_OKAY;
        s_r.last = tag_head.last;
    end

endmodule

// ==== tb/tb_app_memory.sv ====
`include "ddr_ctrl_config.svh"

module tb_app_memory (
    input  logic                           clk_if,
    input  logic                           resetn,
    input  logic                           app_cmd_en,
    input  logic [2:0]                     app_cmd,
    input  logic [`DDR_APP_ADDR_WIDTH-1:0] app_addr,
    output logic                           app_cmd_rdy,
    input  logic                           app_wdf_wren,
    input  logic [`DDR_DATA_WIDTH-1:0]     app_wdf_data,
    input  logic [`DDR_STRB_WIDTH-1:0]     app_wdf_mask,
    output logic                           app_wdf_rdy,
    output logic [`DDR_DATA_WIDTH-1:0]     app_rd_data,
    output logic                           app_rd_data_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`DDR_APP_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [`DDR_DATA_WIDTH-1:0]     word_t;

    word_t                         mem [1 << `DDR_APP_ADDR_WIDTH];
    word_addr_t                    wr_addr_q [$];
    word_t                         wr_data_q [$];
    logic [`DDR_STRB_WIDTH-1:0]    wr_mask_q [$];
    word_t                         rd_data_q [$];
    int                            rd_due_q [$];
    int                            cycle = 0;
    int                            last_due = 0;

    initial begin
        word_addr_t a;
        for (int i = 0; i < (1 << `DDR_APP_ADDR_WIDTH); i++) begin
            a = word_addr_t'(i);
            mem[a] = {2'b10, a, 2'b01, ~a};  // every bit of the address shows up
        end
    end

    // transfers are decided at the falling edge, inputs are stable by then
    always @(negedge clk_if) begin
        word_addr_t a;
        int due;
        if (resetn && app_wdf_wren && app_wdf_rdy) begin
            wr_data_q.push_back(app_wdf_data);
            wr_mask_q.push_back(app_wdf_mask);
        end
        if (resetn && app_cmd_en && app_cmd_rdy && app_cmd == 3'b000) wr_addr_q.push_back(app_addr);
        while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
            a = wr_addr_q.pop_front();
            for (int b = 0; b < `DDR_STRB_WIDTH; b++) begin
                if (!wr_mask_q[0][b]) mem[a][8*b +: 8] = wr_data_q[0][8*b +: 8];
            end
            void'(wr_data_q.pop_front());
            void'(wr_mask_q.pop_front());
        end
        if (resetn && app_cmd_en && app_cmd_rdy && app_cmd == 3'b001) begin
            due = cycle + 3 + int'($urandom % 4);  // 2 to 5 cycles after accept
            if (due <= last_due) due = last_due + 1;  // keep command order
            last_due = due;
            rd_due_q.push_back(due);
            rd_data_q.push_back(mem[app_addr]);
        end
    end

    initial begin
        app_cmd_rdy       = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        forever begin
            @(posedge clk_if);
            cycle = cycle + 1;
            #1;
            app_cmd_rdy = resetn && (($urandom % 4) != 0);
            app_wdf_rdy = resetn && (($urandom % 4) != 0);
            if (resetn && rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                app_rd_data_valid = 1'b1;
                app_rd_data       = rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end else begin
                app_rd_data_valid = 1'b0;
            end
        end
    end

endmodule

// ==== tb/tb_ddr_ctrl.sv ====
`include "ddr_ctrl_config.svh"

module tb_ddr_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`DDR_APP_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [`DDR_DATA_WIDTH-1:0]     word_t;
    typedef logic [`DDR_ID_WIDTH-1:0]       id_t;

    localparam int HANDSHAKE_LIMIT = 200;
    localparam int DRAIN_LIMIT     = 2000;

    logic                               clk_if = 1'b0;
    logic                               resetn;
    logic                               init_calib_complete;
    ddr_axi_pkg::axi_addr_t             s_aw;
    logic                               s_aw_valid;
    logic                               s_aw_ready;
    ddr_axi_pkg::axi_w_t                s_w;
    logic                               s_w_valid;
    logic                               s_w_ready;
    ddr_axi_pkg::axi_b_t                s_b;
    logic                               s_b_valid;
    logic                               s_b_ready;
    ddr_axi_pkg::axi_addr_t             s_ar;
    logic                               s_ar_valid;
    logic                               s_ar_ready;
    ddr_axi_pkg::axi_r_t                s_r;
    logic                               s_r_valid;
    logic                               s_r_ready;
    logic                               app_cmd_en;
    logic [2:0]                         app_cmd;
    word_addr_t                         app_addr;
    logic                               app_cmd_rdy;
    logic                               app_wdf_wren;
    word_t                              app_wdf_data;
    logic [`DDR_STRB_WIDTH-1:0]         app_wdf_mask;
    logic                               app_wdf_rdy;
    word_t                              app_rd_data;
    logic                               app_rd_data_valid;

    word_t                  shadow [1 << `DDR_APP_ADDR_WIDTH];
    ddr_axi_pkg::axi_r_t    exp_r_q [$];
    id_t                    exp_b_q [$];
    int                     errors = 0;
    int                     timeouts = 0;
    int                     r_beats_seen = 0;
    int                     r_beats_expected = 0;
    int                     b_seen = 0;

    ddr_ctrl_top u_ddr_ctrl_top (.*);
    tb_app_memory u_app_memory (.*);

    always #5 clk_if = ~clk_if;

    function automatic word_t initial_word(input word_addr_t a);
        return {2'b10, a, 2'b01, ~a};
    endfunction

    function automatic word_t expected_word(input word_addr_t a);
        return shadow[a];
    endfunction

    function automatic logic channel_ready(input string ch);
        if (ch == "AW") return s_aw_ready;
        if (ch == "W") return s_w_ready;
        return s_ar_ready;
    endfunction

    task automatic await_handshake(input string ch, output bit ok);
        int n;
        n = 0;
        @(negedge clk_if);
        while (!channel_ready(ch) && n < HANDSHAKE_LIMIT) begin
            @(negedge clk_if);
            n++;
        end
        ok = channel_ready(ch);
        if (!ok) begin
            timeouts++;
            $display("no %s handshake within %0d cycles at %0t", ch, HANDSHAKE_LIMIT, $time);
        end
    endtask

    task automatic write_burst(input id_t id, input word_addr_t word, input int len,
                               input bit rand_strb);
        bit ok;
        word_addr_t a;
        s_aw.id    = id;
        s_aw.addr  = {word, 2'b00};
        s_aw.len   = 8'(len);
        s_aw_valid = 1'b1;
        await_handshake("AW", ok);
        @(posedge clk_if);
        #1;
        s_aw_valid = 1'b0;
        if (!ok) return;
        exp_b_q.push_back(id);
        a = word;
        for (int b = 0; b <= len; b++) begin
            s_w.data  = $urandom;
            s_w.strb  = rand_strb ? 4'($urandom) : '1;
            s_w.last  = (b == len);
            s_w_valid = 1'b1;
            await_handshake("W", ok);
            if (!ok) break;
            for (int k = 0; k < `DDR_STRB_WIDTH; k++) begin
                if (s_w.strb[k]) shadow[a][8*k +: 8] = s_w.data[8*k +: 8];
            end
            a = a + 1'b1;
            @(posedge clk_if);
            #1;
        end
        s_w_valid = 1'b0;
    endtask

    task automatic read_burst(input id_t id, input word_addr_t word, input int len);
        bit ok;
        word_addr_t a;
        ddr_axi_pkg::axi_r_t e;
        s_ar.id    = id;
        s_ar.addr  = {word, 2'b00};
        s_ar.len   = 8'(len);
        s_ar_valid = 1'b1;
        await_handshake("AR", ok);
        if (ok) begin
            a = word;
            for (int b = 0; b <= len; b++) begin
                e.id   = id;
                e.data = expected_word(a);
                e.resp = ddr_axi_pkg::AXI_RESP_OKAY;
                e.last = (b == len);
                exp_r_q.push_back(e);
                a = a + 1'b1;
            end
            r_beats_expected += len + 1;
        end
        @(posedge clk_if);
        #1;
        s_ar_valid = 1'b0;
    endtask

    // B and R back-pressure
    initial begin
        s_b_ready = 1'b0;
        s_r_ready = 1'b0;
        forever begin
            @(posedge clk_if);
            #1;
            s_b_ready = ($urandom % 3) != 0;
            s_r_ready = ($urandom % 3) != 0;
        end
    end

    always @(negedge clk_if) begin
        ddr_axi_pkg::axi_r_t e;
        if (resetn && s_r_valid && s_r_ready) begin
            r_beats_seen++;
            if (exp_r_q.size() == 0) begin
                errors++;
                $display("R beat at %0t with no read outstanding", $time);
            end else begin
                e = exp_r_q.pop_front();
                if (s_r !== e) begin
                    errors++;
                    $display("Error at %0t: R id %h data %h resp %b last %b, expected %h %h %b %b",
                             $time, s_r.id, s_r.data, s_r.resp, s_r.last,
                             e.id, e.data, e.resp, e.last);
                end
            end
        end
        if (resetn && s_b_valid && s_b_ready) begin
            b_seen++;
            if (exp_b_q.size() == 0) begin
                errors++;
                $display("B response at %0t with no write outstanding", $time);
            end else if (s_b.id !== exp_b_q[0] || s_b.resp !== ddr_axi_pkg::AXI_RESP_OKAY) begin
                errors++;
                $display("Error at %0t: B id %h resp %b, expected id %h resp 00",
                         $time, s_b.id, s_b.resp, exp_b_q[0]);
            end
            if (exp_b_q.size() > 0) void'(exp_b_q.pop_front());
        end
    end

    initial begin
        word_addr_t a;
        int n;
        void'($urandom(34));
        for (int i = 0; i < (1 << `DDR_APP_ADDR_WIDTH); i++) begin
            a = word_addr_t'(i);
            shadow[a] = initial_word(a);
        end
        resetn              = 1'b0;
        init_calib_complete = 1'b0;
        s_aw                = '0;
        s_aw_valid          = 1'b0;
        s_w                 = '0;
        s_w_valid           = 1'b0;
        s_ar                = '0;
        s_ar_valid          = 1'b0;
        repeat (5) @(posedge clk_if);
        #1;
        resetn = 1'b1;

        // requests wait while calibration runs
        s_aw_valid = 1'b1;
        s_ar.addr  = 16'h0040;
        s_ar_valid = 1'b1;
        repeat (5) begin
            @(negedge clk_if);
            if (s_b_valid || s_r_valid || app_cmd_en || app_wdf_wren
                    || s_aw_ready || s_w_ready || s_ar_ready) begin
                errors++;
                $display("Error at %0t: outputs active before calibration", $time);
            end
        end
        @(posedge clk_if);
        #1;
        init_calib_complete = 1'b1;
        write_burst(4'h0, 14'h0000, 0, 1'b0);  // held AW wins the first tie
        read_burst(4'h0, 14'h0010, 0);

        write_burst(4'h3, 14'h0100, 0, 1'b0);
        read_burst(4'h5, 14'h0100, 0);
        write_burst(4'h6, 14'h0100, 3, 1'b1);  // partial strobes over the same words
        write_burst(4'h8, 14'h0102, 3, 1'b1);
        read_burst(4'h7, 14'h0100, 5);

        for (int t = 0; t < 40; t++) begin
            if (($urandom % 2) != 0) begin
                write_burst(id_t'($urandom), word_addr_t'($urandom % 32), int'($urandom % 8),
                            ($urandom % 2) != 0);
            end else begin
                read_burst(id_t'($urandom), word_addr_t'($urandom % 32), int'($urandom % 8));
            end
        end

        n = 0;
        while ((exp_r_q.size() > 0 || exp_b_q.size() > 0) && n < DRAIN_LIMIT) begin
            @(negedge clk_if);
            n++;
        end
        if (exp_r_q.size() > 0 || exp_b_q.size() > 0) begin
            timeouts++;
            $display("responses still missing after drain: %0d R, %0d B",
                     exp_r_q.size(), exp_b_q.size());
        end
        repeat (10) @(negedge clk_if);  // catch stray beats
        if (r_beats_seen != r_beats_expected) begin
            errors++;
            $display("Error at %0t: %0d R beats seen, %0d expected",
                     $time, r_beats_seen, r_beats_expected);
        end
        $display("errors %0d, timeouts %0d, R beats %0d of %0d, B responses %0d",
                 errors, timeouts, r_beats_seen, r_beats_expected, b_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== ddr_ctrl_top.f ====
+incdir+src
src/ddr_axi_pkg.sv
src/ddr_app_pkg.sv
src/ddr_sync_fifo.sv
src/axi_beat_splitter.sv
src/ddr_app_sequencer.sv
src/ddr_ctrl_top.sv
tb/tb_app_memory.sv
tb/tb_ddr_ctrl.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_ddr_ctrl
FILELIST := ddr_ctrl_top.f
PASS_MSG := === PASS ===

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
